// ==== hw/lsu_consts.svh ====
// Widths assume a 32-bit word of four 8-bit lanes; address bits above LSU_DMEM_AW+1 wrap
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Virtual address and data word
`define LSU_AW 32
`define LSU_DW 32

// Byte lane width
`define LSU_BW 8

// Byte lanes per word
`define LSU_BYTES 4

// Data memory word index, 256 words
`define LSU_DMEM_AW 8

// Stage-1 valid after reset
`define LSU_S1_VALID_RST 1'b0

`endif

// ==== hw/lsu_pkg.sv ====
// LSU types only; size encoding follows the CPU opcode bus and op value 3 is treated as a no-op
`include "lsu_consts.svh"

package lsu_pkg;

   typedef enum logic [1:0] {
      LSU_NOP   = 2'd0,
      LSU_LOAD  = 2'd1,
      LSU_STORE = 2'd2
   } lsu_op_e;

   // Same codes as the execute-stage size field
   typedef enum logic [2:0] {
      SIZE_B = 3'd1,
      SIZE_H = 3'd2,
      SIZE_W = 3'd3
   } lsu_size_e;

   // Opcode bus from execute
   typedef struct packed {
      lsu_op_e   op;
      lsu_size_e size;
      logic      sign_ext;
   } lsu_opc_t;

   typedef struct packed {
      logic                    en;
      logic                    we;
      logic [`LSU_BYTES-1:0]   wmsk;
      logic [`LSU_DW-1:0]      wdat;
      logic [`LSU_DMEM_AW-1:0] idx;   // Word index
   } lsu_mem_req_t;

   typedef struct packed {
      logic              valid;
      logic              load;
      logic              misalign;
      logic              sign_ext;
      lsu_size_e         size;
      logic [`LSU_AW-1:0] vaddr;
   } lsu_s1_t;

   typedef struct packed {
      logic               valid;
      logic               ealign;   // Misalignment exception
      logic [`LSU_AW-1:0] vaddr;
      logic [`LSU_DW-1:0] dout;
   } lsu_resp_t;

endpackage

// ==== hw/lsu_req_gen.sv ====
// Stage-1 request former; requests fire only with p_ce_s1 high and misaligned stores are dropped
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_req_gen (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  p_ce_s1,
   input  logic                  flush_s1,
   input  logic                  ex_valid,
   input  lsu_pkg::lsu_opc_t     ex_opc,
   input  logic [`LSU_DW-1:0]    add_sum,
   input  logic [`LSU_DW-1:0]    ex_operand2,
   output logic                  agu_en,
   output lsu_pkg::lsu_mem_req_t mem_req,
   output lsu_pkg::lsu_s1_t      s1
);
   import lsu_pkg::*;

   logic                  is_load;
   logic                  is_store;
   logic                  misalign;
   logic                  accept;
   logic [`LSU_DW-1:0]    wdat;
   logic [`LSU_BYTES-1:0] wmsk;
   lsu_s1_t               s1_d;
   lsu_s1_t               s1_q;
   logic                  valid_q;

   assign is_load  = (ex_opc.op == LSU_LOAD);
   assign is_store = (ex_opc.op == LSU_STORE);
   assign agu_en   = is_load | is_store;

   // Word needs both low bits clear, halfword only bit 0
   assign misalign = ((ex_opc.size == SIZE_W) & (|add_sum[1:0])) |
                     ((ex_opc.size == SIZE_H) & add_sum[0]);

   // Held off while the pipe is stalled so a request is not repeated
   assign accept = p_ce_s1 & ex_valid & ~flush_s1 & agu_en;

   // Replicate store data over the lanes and pick the byte enables
   always_comb begin
      wdat = ex_operand2;
      wmsk = '0;
      case (ex_opc.size)
         SIZE_B: begin
            wdat = {`LSU_BYTES{ex_operand2[`LSU_BW-1:0]}};
            wmsk = {{(`LSU_BYTES-1){1'b0}}, 1'b1} << add_sum[1:0];
         end
         SIZE_H: begin
            wdat = {(`LSU_BYTES/2){ex_operand2[2*`LSU_BW-1:0]}};
            wmsk = add_sum[1] ? 4'b1100 : 4'b0011;   // Upper or lower pair
         end
         SIZE_W: begin
            wmsk = '1;
         end
         default: begin
            wmsk = '0;   // Unused size code writes nothing
         end
      endcase
   end

   always_comb begin
      mem_req.en   = accept;
      mem_req.we   = accept & is_store & ~misalign;
      mem_req.wmsk = wmsk;
      mem_req.wdat = wdat;
      mem_req.idx  = add_sum[`LSU_DMEM_AW+1:2];   // Higher bits ignored
   end

   assign s1_d = '{valid:    accept,
                   load:     is_load,
                   misalign: misalign,
                   sign_ext: ex_opc.sign_ext,
                   size:     ex_opc.size,
                   vaddr:    add_sum};

   // Valid also loads on flush so a flush clears it during a stall
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= `LSU_S1_VALID_RST;
      end else if (p_ce_s1 | flush_s1) begin
         valid_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (p_ce_s1) begin
         s1_q <= s1_d;
      end
   end

   always_comb begin
      s1       = s1_q;
      s1.valid = valid_q;
   end

   // A store that wrote memory must land in stage 1 as an aligned store
   a_no_misalign_we: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req.we |=> (s1.valid && !s1.load && !s1.misalign));

endmodule

// ==== hw/lsu_dmem.sv ====
// Byte-masked data RAM with contents not reset; read register is write-first and updates only on en
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_dmem (
   input  logic                  clk,
   input  lsu_pkg::lsu_mem_req_t mem_req,
   output logic [`LSU_DW-1:0]    rdata
);
   localparam int DEPTH = 1 << `LSU_DMEM_AW;

   logic [`LSU_BYTES-1:0][`LSU_BW-1:0] mem [DEPTH];
   logic [`LSU_BYTES-1:0][`LSU_BW-1:0] wbytes;
   logic [`LSU_BYTES-1:0][`LSU_BW-1:0] rbytes_q;

   assign wbytes = mem_req.wdat;   // Lane view of write data

   always_ff @(posedge clk) begin
      if (mem_req.en) begin
         for (int b = 0; b < `LSU_BYTES; b++) begin
            if (mem_req.we && mem_req.wmsk[b]) begin
               mem[mem_req.idx][b] <= wbytes[b];
               rbytes_q[b]         <= wbytes[b];   // New byte seen at once
            end else begin
               rbytes_q[b] <= mem[mem_req.idx][b];
            end
         end
      end
   end

   assign rdata = rbytes_q;

   // Masks from the request former are one byte, an aligned pair or the full word
   a_wmsk_legal: assert property (@(posedge clk)
      mem_req.we |-> (mem_req.wmsk inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                           4'b0011, 4'b1100, 4'b1111}));

endmodule

// ==== hw/lsu_load_align.sv ====
// Purely combinational load lane select and extension; dout is zero for stores
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_load_align (
   input  lsu_pkg::lsu_s1_t   s1,
   input  logic [`LSU_DW-1:0] rdata,
   output lsu_pkg::lsu_resp_t lsu_resp
);
   import lsu_pkg::*;

   logic [`LSU_BW-1:0]   dout_8b;
   logic [2*`LSU_BW-1:0] dout_16b;
   logic                 sbit_8b;
   logic                 sbit_16b;
   logic [`LSU_DW-1:0]   dout_ext;

   // Byte by vaddr[1:0], halfword by vaddr[1]
   assign dout_8b  = rdata[s1.vaddr[1:0]*`LSU_BW +: `LSU_BW];
   assign dout_16b = s1.vaddr[1] ? rdata[`LSU_DW-1 -: 2*`LSU_BW]
                                 : rdata[2*`LSU_BW-1:0];

   assign sbit_8b  = s1.sign_ext & dout_8b[`LSU_BW-1];
   assign sbit_16b = s1.sign_ext & dout_16b[2*`LSU_BW-1];

   always_comb begin
      case (s1.size)
         SIZE_B:  dout_ext = {{(`LSU_DW-`LSU_BW){sbit_8b}}, dout_8b};
         SIZE_H:  dout_ext = {{(`LSU_DW-2*`LSU_BW){sbit_16b}}, dout_16b};
         SIZE_W:  dout_ext = rdata;   // Word passes through
         default: dout_ext = '0;
      endcase
   end

   always_comb begin
      lsu_resp.valid  = s1.valid;
      lsu_resp.ealign = s1.valid & s1.misalign;   // Only for a live request
      lsu_resp.vaddr  = s1.vaddr;
      lsu_resp.dout   = s1.load ? dout_ext : '0;
   end

endmodule

// ==== hw/lsu_top.sv ====
// LSU top with fixed one-cycle latency; there is no stall output and p_ce_s1 is the only flow control
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               p_ce_s1,
   input  logic               flush_s1,
   input  logic               ex_valid,
   input  lsu_pkg::lsu_opc_t  ex_opc,
   input  logic [`LSU_DW-1:0] add_sum,
   input  logic [`LSU_DW-1:0] ex_operand2,
   output logic               agu_en,
   output lsu_pkg::lsu_resp_t lsu_resp
);
   import lsu_pkg::*;

   lsu_mem_req_t       mem_req;
   lsu_s1_t            s1;
   logic [`LSU_DW-1:0] rdata;   // Word read for the stage-1 request

   lsu_req_gen u_req_gen (
      .clk         (clk),
      .arst_n      (arst_n),
      .p_ce_s1     (p_ce_s1),
      .flush_s1    (flush_s1),
      .ex_valid    (ex_valid),
      .ex_opc      (ex_opc),
      .add_sum     (add_sum),
      .ex_operand2 (ex_operand2),
      .agu_en      (agu_en),
      .mem_req     (mem_req),
      .s1          (s1)
   );

   // Stands in for the data cache
   lsu_dmem u_dmem (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (rdata)
   );

   lsu_load_align u_load_align (
      .s1       (s1),
      .rdata    (rdata),
      .lsu_resp (lsu_resp)
   );

endmodule

// ==== verif/tb_clkgen.sv ====
// Free-running testbench clock; reset is released on a falling edge after RST_CYCLES rising edges
`timescale 1ns/100ps

module tb_clkgen #(
   parameter real PERIOD     = 10.0,
   parameter int  RST_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);   // Away from the active edge
      arst_n = 1'b1;
   end

endmodule

// ==== verif/tb_lsu.sv ====
// LSU testbench; assumes one-cycle latency and a 1 KiB data memory whose addresses wrap
`timescale 1ns/100ps
`include "lsu_consts.svh"

module tb_lsu;
   import lsu_pkg::*;

   localparam int          WORDS      = 1 << `LSU_DMEM_AW;
   localparam int          REF_BYTES  = WORDS * `LSU_BYTES;
   localparam int          N_RANDOM   = 500;
   localparam int          MAX_CYCLES = 4 * (2 * WORDS + N_RANDOM);   // Fill, readback, random
   localparam logic [31:0] SEED       = 32'h66c1_8bad;

   logic               clk;
   logic               arst_n;
   logic               p_ce_s1;
   logic               flush_s1;
   logic               ex_valid;
   lsu_opc_t           ex_opc;
   logic [`LSU_DW-1:0] add_sum;
   logic [`LSU_DW-1:0] ex_operand2;
   logic               agu_en;
   lsu_resp_t          resp;

   logic [`LSU_BW-1:0] ref_mem [REF_BYTES];   // Byte image of the data memory
   lsu_resp_t          last_exp;
   bit                 last_full;
   lsu_resp_t          exp_q [$];
   bit                 full_q [$];
   bit                 agu_q [$];
   string              name_q [$];
   int                 n_checks;
   int                 n_resp_err;
   int                 n_data_err;
   int                 n_other_err;
   int                 cycles;

   tb_clkgen #(.PERIOD(10.0), .RST_CYCLES(3)) u_clkgen (.clk(clk), .arst_n(arst_n));

   lsu_top UUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .p_ce_s1     (p_ce_s1),
      .flush_s1    (flush_s1),
      .ex_valid    (ex_valid),
      .ex_opc      (ex_opc),
      .add_sum     (add_sum),
      .ex_operand2 (ex_operand2),
      .agu_en      (agu_en),
      .lsu_resp    (resp)
   );

   function automatic bit misaligned(lsu_size_e size, logic [31:0] addr);
      return ((size == SIZE_W) && (addr[1:0] != 2'b00)) || ((size == SIZE_H) && addr[0]);
   endfunction

   // Odd multiplier gives a distinct fill value for every address
   function automatic logic [31:0] fill_word(logic [31:0] addr);
      return (addr * 32'h9e37_79b9) ^ 32'ha5c3_0f96;
   endfunction

   // Little-endian word at addr with the upper address bits wrapped
   function automatic logic [31:0] ref_word(logic [31:0] addr);
      logic [`LSU_DMEM_AW-1:0] wi;
      wi = addr[`LSU_DMEM_AW+1:2];
      return {ref_mem[{wi, 2'd3}], ref_mem[{wi, 2'd2}], ref_mem[{wi, 2'd1}], ref_mem[{wi, 2'd0}]};
   endfunction

   function automatic void ref_store(lsu_size_e size, logic [31:0] addr, logic [31:0] data);
      logic [`LSU_DMEM_AW-1:0] wi;
      wi = addr[`LSU_DMEM_AW+1:2];
      if (!misaligned(size, addr)) begin   // Misaligned stores leave memory alone
         case (size)
            SIZE_B: ref_mem[{wi, addr[1:0]}] = data[7:0];
            SIZE_H: begin
               ref_mem[{wi, addr[1], 1'b0}] = data[7:0];
               ref_mem[{wi, addr[1], 1'b1}] = data[15:8];
            end
            SIZE_W: begin
               ref_mem[{wi, 2'd0}] = data[7:0];
               ref_mem[{wi, 2'd1}] = data[15:8];
               ref_mem[{wi, 2'd2}] = data[23:16];
               ref_mem[{wi, 2'd3}] = data[31:24];
            end
            default: ;
         endcase
      end
   endfunction

   // Result of an accepted request against the current memory image
   function automatic lsu_resp_t ref_resp(lsu_opc_t opc, logic [31:0] addr);
      lsu_resp_t   r;
      logic [31:0] w;
      logic [7:0]  b;
      logic [15:0] h;
      w        = ref_word(addr);
      b        = 8'(w >> {addr[1:0], 3'b000});
      h        = addr[1] ? w[31:16] : w[15:0];
      r.valid  = 1'b1;
      r.ealign = misaligned(opc.size, addr);
      r.vaddr  = addr;
      r.dout   = '0;   // Stores return no data
      if (opc.op == LSU_LOAD) begin
         case (opc.size)
            SIZE_B:  r.dout = opc.sign_ext ? {{24{b[7]}}, b} : {24'd0, b};
            SIZE_H:  r.dout = opc.sign_ext ? {{16{h[15]}}, h} : {16'd0, h};
            default: r.dout = w;
         endcase
      end
      return r;
   endfunction

   task automatic check_resp(string name, lsu_resp_t want, lsu_resp_t got, bit with_addr);
      n_checks++;
      if (got.valid !== want.valid || got.ealign !== want.ealign ||
          (with_addr && got.vaddr !== want.vaddr)) begin
         n_resp_err++;
         $display("FAILED %s: valid/ealign/vaddr expected %0b/%0b/%h actual %0b/%0b/%h",
                  name, want.valid, want.ealign, want.vaddr, got.valid, got.ealign, got.vaddr);
      end
   endtask

   task automatic check_data(string name, logic [`LSU_DW-1:0] want, logic [`LSU_DW-1:0] got);
      n_checks++;
      if (got !== want) begin
         n_data_err++;
         $display("FAILED %s: dout expected %h actual %h", name, want, got);
      end
   endtask

   task automatic check_agu(string name, logic want, logic got);
      n_checks++;
      if (got !== want) begin
         n_other_err++;
         $display("FAILED %s: agu_en expected %0b actual %0b", name, want, got);
      end
   endtask

   // One cycle of stimulus on the falling edge, with the expected response queued
   task automatic issue(string name, bit ce, bit flush, bit vld, lsu_op_e op,
                        lsu_size_e size, bit sx, logic [31:0] addr, logic [31:0] data);
      lsu_opc_t  opc;
      lsu_resp_t want;
      bit        full;
      bit        accept;
      @(negedge clk);
      opc.op       = op;
      opc.size     = size;
      opc.sign_ext = sx;
      p_ce_s1      = ce;
      flush_s1     = flush;
      ex_valid     = vld;
      ex_opc       = opc;
      add_sum      = addr;
      ex_operand2  = data;
      accept       = ce && vld && !flush && (op != LSU_NOP);
      if (accept) begin
         want = ref_resp(opc, addr);
         full = 1'b1;
         if (op == LSU_STORE) ref_store(size, addr, data);
      end else if (ce || flush) begin
         want        = last_exp;   // Only valid and ealign are known here
         want.valid  = 1'b0;
         want.ealign = 1'b0;
         full        = 1'b0;
      end else begin
         want = last_exp;   // Stalled response holds
         full = last_full;
      end
      last_exp  = want;
      last_full = full;
      exp_q.push_back(want);
      full_q.push_back(full);
      agu_q.push_back(op != LSU_NOP);
      name_q.push_back(name);
   endtask

   task automatic store_req(string name, lsu_size_e size, logic [31:0] addr, logic [31:0] data);
      issue(name, 1'b1, 1'b0, 1'b1, LSU_STORE, size, 1'b0, addr, data);
   endtask

   task automatic load_req(string name, lsu_size_e size, bit sx, logic [31:0] addr);
      issue(name, 1'b1, 1'b0, 1'b1, LSU_LOAD, size, sx, addr, '0);
   endtask

   task automatic report();
      int total;
      total = n_resp_err + n_data_err + n_other_err;
      $display("Checks %0d, response errors %0d, data errors %0d, other errors %0d",
               n_checks, n_resp_err, n_data_err, n_other_err);
      if (total == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   initial begin : compare_results
      lsu_resp_t want;
      bit        full;
      bit        agu;
      string     name;
      forever begin
         @(posedge clk);
         if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            full = full_q.pop_front();
            agu  = agu_q.pop_front();
            name = name_q.pop_front();
            check_agu(name, agu, agu_en);   // Inputs still settled at this edge
            @(negedge clk);
            check_resp(name, want, resp, full);
            if (full) check_data(name, want.dout, resp.dout);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         n_other_err++;
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         report();
      end
   end

   initial begin : stimulus
      logic [31:0] addr;
      logic [31:0] data;
      lsu_op_e     op;
      lsu_size_e   size;
      bit          ce;
      bit          flush;
      bit          sx;
      int          r;
      void'($urandom(SEED));
      p_ce_s1         = 1'b0;
      flush_s1        = 1'b0;
      ex_valid        = 1'b0;
      ex_opc.op       = LSU_NOP;
      ex_opc.size     = SIZE_W;
      ex_opc.sign_ext = 1'b0;
      add_sum         = '0;
      ex_operand2     = '0;
      last_exp        = '0;
      last_full       = 1'b0;
      @(posedge arst_n);
      check_resp("reset", '0, resp, 1'b0);

      // Word fill of the whole memory and readback
      for (int w = 0; w < WORDS; w++) begin
         store_req("word fill", SIZE_W, 32'(w) << 2, fill_word(32'(w) << 2));
      end
      for (int w = 0; w < WORDS; w++) load_req("word readback", SIZE_W, 1'b0, 32'(w) << 2);

      // Lane stores merge with old bytes
      for (int b = 0; b < 4; b++) begin
         store_req("byte store", SIZE_B, 32'h20 + 32'(b), 32'h0000_0080 + 32'(b));
         load_req("byte merge", SIZE_W, 1'b0, 32'h20);
      end
      store_req("half store low", SIZE_H, 32'h24, 32'h1234_c3d2);
      load_req("half merge low", SIZE_W, 1'b0, 32'h24);
      store_req("half store high", SIZE_H, 32'h26, 32'hffff_8e71);
      load_req("half merge high", SIZE_W, 1'b0, 32'h24);

      // Sign and zero extension with top bits set and clear
      store_req("sign pattern", SIZE_W, 32'h28, 32'h80ff_7f01);
      store_req("sign pattern", SIZE_W, 32'h2c, 32'h7fff_8000);
      for (int b = 0; b < 8; b++) begin
         load_req("byte load signed", SIZE_B, 1'b1, 32'h28 + 32'(b));
         load_req("byte load unsigned", SIZE_B, 1'b0, 32'h28 + 32'(b));
      end
      for (int h = 0; h < 4; h++) begin
         load_req("half load signed", SIZE_H, 1'b1, 32'h28 + 32'(2 * h));
         load_req("half load unsigned", SIZE_H, 1'b0, 32'h28 + 32'(2 * h));
      end

      load_req("misaligned word load", SIZE_W, 1'b0, 32'h31);
      load_req("misaligned half load", SIZE_H, 1'b1, 32'h33);
      store_req("misaligned word store", SIZE_W, 32'h32, 32'hdead_beef);
      store_req("misaligned half store", SIZE_H, 32'h35, 32'h0000_beef);
      load_req("after misaligned store", SIZE_W, 1'b0, 32'h30);
      load_req("after misaligned store", SIZE_W, 1'b0, 32'h34);

      // Stall, flush and idle cycles
      load_req("before stall", SIZE_W, 1'b0, 32'h40);
      repeat (3) begin
         issue("stalled store", 1'b0, 1'b0, 1'b1, LSU_STORE, SIZE_W, 1'b0, 32'h40,
               32'h0bad_f00d);
      end
      load_req("after stall", SIZE_W, 1'b0, 32'h40);
      issue("flushed store", 1'b1, 1'b1, 1'b1, LSU_STORE, SIZE_W, 1'b0, 32'h44, 32'h1357_9bdf);
      load_req("after flush", SIZE_W, 1'b0, 32'h44);
      issue("flush in stall", 1'b0, 1'b1, 1'b1, LSU_LOAD, SIZE_W, 1'b0, 32'h48, '0);
      issue("hold after flush", 1'b0, 1'b0, 1'b1, LSU_LOAD, SIZE_W, 1'b0, 32'h48, '0);
      issue("store without valid", 1'b1, 1'b0, 1'b0, LSU_STORE, SIZE_W, 1'b0, 32'h4c, '1);
      load_req("after invalid store", SIZE_W, 1'b0, 32'h4c);

      for (int i = 0; i < N_RANDOM; i++) begin
         r    = $urandom_range(9);
         op   = (r == 0) ? LSU_NOP : ((r < 5) ? LSU_LOAD : LSU_STORE);
         r    = $urandom_range(2);
         size = (r == 0) ? SIZE_B : ((r == 1) ? SIZE_H : SIZE_W);
         addr = $urandom;
         if ($urandom_range(3) != 0) begin   // Mostly aligned
            if (size == SIZE_W) addr[1:0] = 2'b00;
            else if (size == SIZE_H) addr[0] = 1'b0;
         end
         data  = $urandom;
         sx    = ($urandom_range(1) == 1);
         ce    = ($urandom_range(7) != 0);
         flush = ($urandom_range(31) == 0);
         issue("random", ce, flush, 1'b1, op, size, sx, addr, data);
      end

      issue("idle", 1'b1, 1'b0, 1'b0, LSU_NOP, SIZE_W, 1'b0, '0, '0);
      while (exp_q.size() != 0) @(negedge clk);
      @(negedge clk);
      #1;
      report();
   end

endmodule

// ==== compile.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_req_gen.sv
hw/lsu_dmem.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verif/tb_clkgen.sv
verif/tb_lsu.sv

// ==== Makefile ====
SIM = obj_dir/sim_lsu

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module tb_lsu -o sim_lsu

# Fails unless the pass line is found in the simulation output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
